// File: src.f
src/mbox_pkg.sv
src/axil_if.sv
src/sync_fifo.sv
src/axil_regs.sv
src/mbox_top.sv
tests/mbox_props.sv
tests/mbox_tb.sv

// File: Makefile
SIM = obj_dir/mbox_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wall -Wno-fatal -f src.f \
		--top-module mbox_tb -o mbox_sim --Mdir obj_dir

run: compile
	-./$(SIM) > sim.log 2>&1
	cat sim.log
	grep -q "TEST PASSED" sim.log
	! grep -q "TEST FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/mbox_tb.sv
`timescale 1ns/1ps

module mbox_tb;
    import mbox_pkg::*;

    // table operations
    localparam int OP_WR = 0;
    localparam int OP_RD = 1;
    localparam int OP_SEND = 2;
    localparam int OP_TAKE = 3;
    localparam int OP_IDLE = 4;
    localparam int OP_OFFER = 5;

    typedef struct {
        int          op;
        logic [3:0]  addr;
        logic [31:0] data;
        bit          rnd;
        bit          last;
        logic [1:0]  resp;
    } row_t;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic [ADDR_W-1:0] awaddr, araddr;
    logic awvalid, wvalid, bready, arvalid, rready;
    logic [DATA_W-1:0] wdata, rdata, tx_data, rx_data;
    logic [3:0] wstrb;
    logic awready, wready, bvalid, arready, rvalid;
    logic [1:0] bresp, rresp;
    logic tx_valid, tx_ready, rx_last, rx_valid, rx_ready;

    row_t        rows[$];
    logic [31:0] tx_q[$];
    rx_item_t    rx_q[$];
    int          seed = 32'hf1be_f4f0;
    int unsigned cycles = 0;
    int unsigned cycle_limit = 100000;
    int          take_cnt = 0;

    mbox_top i_mbox_top (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready),
        .s_axil_wdata_i(wdata), .s_axil_wstrb_i(wstrb), .s_axil_wvalid_i(wvalid),
        .s_axil_wready_o(wready), .s_axil_bresp_o(bresp), .s_axil_bvalid_o(bvalid),
        .s_axil_bready_i(bready), .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid),
        .s_axil_arready_o(arready), .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp),
        .s_axil_rvalid_o(rvalid), .s_axil_rready_i(rready),
        .tx_data_o(tx_data), .tx_valid_o(tx_valid), .tx_ready_i(tx_ready),
        .rx_data_i(rx_data), .rx_last_i(rx_last), .rx_valid_i(rx_valid), .rx_ready_o(rx_ready)
    );

    always #50 clk_i = ~clk_i;

    // run limit from the table length
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the test did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input logic [31:0] act, input logic [31:0] exp, input string what);
        if (act !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, act, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "check failed");
        end
    endtask

    // status word as the model queues predict it
    function automatic logic [31:0] model_status();
        logic [31:0] s;
        s = '0;
        s[ST_TX_EMPTY] = (tx_q.size() == 0);
        s[ST_TX_FULL] = (tx_q.size() == TX_DEPTH);
        s[ST_RX_EMPTY] = (rx_q.size() == 0);
        s[ST_RX_FULL] = (rx_q.size() == RX_DEPTH);
        s[ST_RX_LAST] = (rx_q.size() != 0) && rx_q[0].last;
        s[ST_TX_USAGE_LSB +: 4] = 4'(tx_q.size() % TX_DEPTH);
        s[ST_RX_USAGE_LSB +: 4] = 4'(rx_q.size() % RX_DEPTH);
        return s;
    endfunction

    task automatic add(input int op, input logic [3:0] a, input logic [31:0] d,
                       input bit rnd, input bit last, input logic [1:0] resp);
        row_t r;
        r.op = op;
        r.addr = a;
        r.data = d;
        r.rnd = rnd;
        r.last = last;
        r.resp = resp;
        rows.push_back(r);
    endtask

    task automatic axil_write(input logic [3:0] a, input logic [31:0] d, input logic [1:0] er);
        @(posedge clk_i);
        awaddr <= a;
        wdata <= d;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        bready <= 1'b1;
        do @(negedge clk_i); while (!awready);
        check(wready, 1'b1, "wready with awready");
        // apply the effect to the model in the acceptance cycle
        if (a == REG_TXDATA && tx_q.size() < TX_DEPTH) tx_q.push_back(d);
        if (a == REG_CTRL && d[CTRL_TX_FLUSH]) tx_q.delete();
        if (a == REG_CTRL && d[CTRL_RX_FLUSH]) rx_q.delete();
        @(posedge clk_i);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        do @(negedge clk_i); while (!bvalid);
        check(bresp, er, "write response");
        @(posedge clk_i);
        bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] a, input logic [1:0] er);
        logic [31:0] exp;
        rx_item_t    head;
        @(posedge clk_i);
        araddr <= a;
        arvalid <= 1'b1;
        rready <= 1'b1;
        do @(negedge clk_i); while (!arready);
        exp = '0;
        if (a == REG_STATUS) begin
            exp = model_status();
            check(tx_valid, tx_q.size() != 0, "tx_valid_o against model");
            check(rx_ready, rx_q.size() != RX_DEPTH, "rx_ready_o against model");
        end else if (a == REG_RXDATA && rx_q.size() != 0) begin
            head = rx_q.pop_front();
            exp = head.data;
        end
        @(posedge clk_i);
        arvalid <= 1'b0;
        do @(negedge clk_i); while (!rvalid);
        check(rresp, er, "read response");
        if (er == RESP_OKAY || a == REG_RXDATA) check(rdata, exp, "read data");
        @(posedge clk_i);
        rready <= 1'b0;
    endtask

    task automatic stream_send(input logic [31:0] d, input bit last);
        rx_item_t it;
        @(posedge clk_i);
        rx_data <= d;
        rx_last <= last;
        rx_valid <= 1'b1;
        do @(negedge clk_i); while (!rx_ready);
        it.data = d;
        it.last = last;
        rx_q.push_back(it);
        @(posedge clk_i);
        rx_valid <= 1'b0;
    endtask

    // offer an item to a full fifo and withdraw it
    task automatic stream_offer(input logic [31:0] d);
        @(posedge clk_i);
        rx_data <= d;
        rx_valid <= 1'b1;
        repeat (3) begin
            @(negedge clk_i);
            check(rx_ready, rx_q.size() != RX_DEPTH, "rx_ready_o while offered");
        end
        @(posedge clk_i);
        rx_valid <= 1'b0;
    endtask

    task automatic stream_take();
        take_cnt++;
        // every other word waits under back-pressure first
        if (take_cnt % 2 == 0) begin
            repeat (2) begin
                @(negedge clk_i);
                check(tx_valid, 1'b1, "tx_valid_o under back-pressure");
                check(tx_data, tx_q[0], "tx_data_o held stable");
            end
        end
        @(posedge clk_i);
        tx_ready <= 1'b1;
        @(negedge clk_i);
        check(tx_valid, 1'b1, "tx_valid_o at take");
        check(tx_data, tx_q.pop_front(), "tx_data_o");
        @(posedge clk_i);
        tx_ready <= 1'b0;
    endtask

    initial begin
        row_t r;
        rst_ni = 1'b0;
        awaddr = '0;
        araddr = '0;
        wdata = '0;
        wstrb = 4'hF;
        rx_data = '0;
        awvalid = 0;
        wvalid = 0;
        bready = 0;
        arvalid = 0;
        rready = 0;
        tx_ready = 0;
        rx_last = 0;
        rx_valid = 0;

        // reset state
        add(OP_RD, REG_STATUS, 0, 0, 0, RESP_OKAY);
        // fill tx, overflow, drain
        repeat (8) add(OP_WR, REG_TXDATA, 0, 1, 0, RESP_OKAY);
        add(OP_RD, REG_STATUS, 0, 0, 0, RESP_OKAY);
        add(OP_WR, REG_TXDATA, 32'hdead_beef, 0, 0, RESP_SLVERR);
        repeat (8) add(OP_TAKE, 0, 0, 0, 0, RESP_OKAY);
        add(OP_RD, REG_STATUS, 0, 0, 0, RESP_OKAY);
        // rx items with last flags
        add(OP_SEND, 0, 0, 1, 0, RESP_OKAY);
        add(OP_SEND, 0, 0, 1, 1, RESP_OKAY);
        add(OP_SEND, 0, 0, 1, 0, RESP_OKAY);
        repeat (3) begin
            add(OP_RD, REG_STATUS, 0, 0, 0, RESP_OKAY);
            add(OP_RD, REG_RXDATA, 0, 0, 0, RESP_OKAY);
        end
        add(OP_RD, REG_RXDATA, 0, 0, 0, RESP_SLVERR);
        // rx full and back-pressure
        add(OP_SEND, 0, 0, 1, 1, RESP_OKAY);
        add(OP_SEND, 0, 0, 1, 0, RESP_OKAY);
        add(OP_SEND, 0, 0, 1, 0, RESP_OKAY);
        add(OP_SEND, 0, 0, 1, 1, RESP_OKAY);
        add(OP_RD, REG_STATUS, 0, 0, 0, RESP_OKAY);
        add(OP_OFFER, 0, 0, 1, 0, RESP_OKAY);
        add(OP_RD, REG_RXDATA, 0, 0, 0, RESP_OKAY);
        add(OP_SEND, 0, 0, 1, 1, RESP_OKAY);
        add(OP_RD, REG_STATUS, 0, 0, 0, RESP_OKAY);
        // flush both fifos
        repeat (3) add(OP_WR, REG_TXDATA, 0, 1, 0, RESP_OKAY);
        add(OP_RD, REG_STATUS, 0, 0, 0, RESP_OKAY);
        add(OP_WR, REG_CTRL, 32'h3, 0, 0, RESP_OKAY);
        add(OP_IDLE, 0, 2, 0, 0, RESP_OKAY);
        add(OP_RD, REG_STATUS, 0, 0, 0, RESP_OKAY);
        // illegal accesses leave status alone
        add(OP_SEND, 0, 0, 1, 1, RESP_OKAY);
        add(OP_WR, REG_TXDATA, 0, 1, 0, RESP_OKAY);
        add(OP_RD, REG_STATUS, 0, 0, 0, RESP_OKAY);
        add(OP_RD, REG_CTRL, 0, 0, 0, RESP_SLVERR);
        add(OP_WR, REG_STATUS, 32'hffff_ffff, 0, 0, RESP_SLVERR);
        add(OP_RD, REG_TXDATA, 0, 0, 0, RESP_SLVERR);
        add(OP_WR, REG_RXDATA, 32'h1234_5678, 0, 0, RESP_SLVERR);
        add(OP_WR, 4'h2, 32'h0000_0003, 0, 0, RESP_SLVERR);
        add(OP_RD, 4'h6, 0, 0, 0, RESP_SLVERR);
        add(OP_RD, REG_STATUS, 0, 0, 0, RESP_OKAY);

        cycle_limit = 40 * rows.size() + 16;
        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;

        foreach (rows[i]) begin
            r = rows[i];
            if (r.rnd) r.data = $random(seed);
            case (r.op)
                OP_WR: axil_write(r.addr, r.data, r.resp);
                OP_RD: axil_read(r.addr, r.resp);
                OP_SEND: stream_send(r.data, r.last);
                OP_TAKE: stream_take();
                OP_OFFER: stream_offer(r.data);
                default: repeat (r.data) @(posedge clk_i);
            endcase
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: tests/mbox_props.sv
`timescale 1ns/1ps

module fifo_props #(
    parameter int unsigned DEPTH = 8
) (
    input logic                     clk_i,
    input logic                     rst_ni,
    input logic                     flush_i,
    input logic                     push_i,
    input logic                     pop_i,
    input logic                     full_o,
    input logic                     empty_o,
    input logic [$clog2(DEPTH)-1:0] usage_o
);

    // the register block qualifies push and pop
    push_not_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !full_o) else $error("push while full");

    pop_not_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> !empty_o) else $error("pop while empty");

    // idle cycle keeps the fill level
    usage_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!push_i && !pop_i && !flush_i) |=> $stable(usage_o))
        else $error("usage changed without push, pop or flush");

endmodule

bind sync_fifo fifo_props #(.DEPTH(DEPTH)) i_fifo_props (.*);

// File: src/mbox_top.sv
`timescale 1ns/1ps

module mbox_top (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    // axi4-lite slave
    input  logic [mbox_pkg::ADDR_W-1:0]   s_axil_awaddr_i,
    input  logic                          s_axil_awvalid_i,
    output logic                          s_axil_awready_o,
    input  logic [mbox_pkg::DATA_W-1:0]   s_axil_wdata_i,
    input  logic [mbox_pkg::DATA_W/8-1:0] s_axil_wstrb_i,
    input  logic                          s_axil_wvalid_i,
    output logic                          s_axil_wready_o,
    output logic [1:0]                    s_axil_bresp_o,
    output logic                          s_axil_bvalid_o,
    input  logic                          s_axil_bready_i,
    input  logic [mbox_pkg::ADDR_W-1:0]   s_axil_araddr_i,
    input  logic                          s_axil_arvalid_i,
    output logic                          s_axil_arready_o,
    output logic [mbox_pkg::DATA_W-1:0]   s_axil_rdata_o,
    output logic [1:0]                    s_axil_rresp_o,
    output logic                          s_axil_rvalid_o,
    input  logic                          s_axil_rready_i,
    // transmit stream
    output logic [mbox_pkg::DATA_W-1:0]   tx_data_o,
    output logic                          tx_valid_o,
    input  logic                          tx_ready_i,
    // receive stream
    input  logic [mbox_pkg::DATA_W-1:0]   rx_data_i,
    input  logic                          rx_last_i,
    input  logic                          rx_valid_i,
    output logic                          rx_ready_o
);
    import mbox_pkg::*;

    logic                  tx_push;
    logic                  tx_pop;
    logic                  tx_flush;
    logic                  tx_full;
    logic                  tx_empty;
    logic [DATA_W-1:0]     tx_wdata;
    logic [TX_USAGE_W-1:0] tx_usage;
    logic                  rx_push;
    logic                  rx_pop;
    logic                  rx_flush;
    logic                  rx_full;
    logic                  rx_empty;
    rx_item_t              rx_item;
    rx_item_t              rx_head;
    logic [RX_USAGE_W-1:0] rx_usage;

    axil_if axil ();

    // master side of the bus comes from the top-level pins
    assign axil.awaddr      = s_axil_awaddr_i;
    assign axil.awvalid     = s_axil_awvalid_i;
    assign axil.wdata       = s_axil_wdata_i;
    assign axil.wstrb       = s_axil_wstrb_i;
    assign axil.wvalid      = s_axil_wvalid_i;
    assign axil.bready      = s_axil_bready_i;
    assign axil.araddr      = s_axil_araddr_i;
    assign axil.arvalid     = s_axil_arvalid_i;
    assign axil.rready      = s_axil_rready_i;
    assign s_axil_awready_o = axil.awready;
    assign s_axil_wready_o  = axil.wready;
    assign s_axil_bresp_o   = axil.bresp;
    assign s_axil_bvalid_o  = axil.bvalid;
    assign s_axil_arready_o = axil.arready;
    assign s_axil_rdata_o   = axil.rdata;
    assign s_axil_rresp_o   = axil.rresp;
    assign s_axil_rvalid_o  = axil.rvalid;

    // transmit stream drains the head, only the stream side pops
    assign tx_valid_o = !tx_empty;
    assign tx_pop     = tx_valid_o && tx_ready_i;

    // receive stream accepts while there is room
    assign rx_ready_o = !rx_full;
    assign rx_push    = rx_valid_i && rx_ready_o;
    assign rx_item    = '{data: rx_data_i, last: rx_last_i};

    axil_regs i_axil_regs (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .bus        (axil.slave),
        .tx_push_o  (tx_push),
        .tx_data_o  (tx_wdata),
        .tx_full_i  (tx_full),
        .tx_empty_i (tx_empty),
        .tx_usage_i (tx_usage),
        .tx_flush_o (tx_flush),
        .rx_pop_o   (rx_pop),
        .rx_head_i  (rx_head),
        .rx_full_i  (rx_full),
        .rx_empty_i (rx_empty),
        .rx_usage_i (rx_usage),
        .rx_flush_o (rx_flush)
    );

    // registered head so a word shows on the stream one cycle after the write
    sync_fifo #(
        .FALL_THROUGH (1'b0),
        .DEPTH        (TX_DEPTH),
        .payload_t    (logic [DATA_W-1:0])
    ) i_tx_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (tx_flush),
        .full_o  (tx_full),
        .empty_o (tx_empty),
        .usage_o (tx_usage),
        .data_i  (tx_wdata),
        .push_i  (tx_push),
        .data_o  (tx_data_o),
        .pop_i   (tx_pop)
    );

    // fall-through so an arriving item can be read in the same cycle
    sync_fifo #(
        .FALL_THROUGH (1'b1),
        .DEPTH        (RX_DEPTH),
        .payload_t    (rx_item_t)
    ) i_rx_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (rx_flush),
        .full_o  (rx_full),
        .empty_o (rx_empty),
        .usage_o (rx_usage),
        .data_i  (rx_item),
        .push_i  (rx_push),
        .data_o  (rx_head),
        .pop_i   (rx_pop)
    );

endmodule

// File: src/axil_regs.sv
`timescale 1ns/1ps

module axil_regs (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    axil_if.slave                           bus,
    // transmit fifo
    output logic                            tx_push_o,
    output logic [mbox_pkg::DATA_W-1:0]     tx_data_o,
    input  logic                            tx_full_i,
    input  logic                            tx_empty_i,
    input  logic [mbox_pkg::TX_USAGE_W-1:0] tx_usage_i,
    output logic                            tx_flush_o,
    // receive fifo
    output logic                            rx_pop_o,
    input  mbox_pkg::rx_item_t              rx_head_i,
    input  logic                            rx_full_i,
    input  logic                            rx_empty_i,
    input  logic [mbox_pkg::RX_USAGE_W-1:0] rx_usage_i,
    output logic                            rx_flush_o
);
    import mbox_pkg::*;

    logic              wr_accept;
    logic              rd_accept;
    logic              bvalid_q;
    logic [1:0]        bresp_d;
    logic [1:0]        bresp_q;
    logic              rvalid_q;
    logic [1:0]        rresp_d;
    logic [1:0]        rresp_q;
    logic [DATA_W-1:0] rdata_d;
    logic [DATA_W-1:0] rdata_q;
    logic [DATA_W-1:0] status;

    // write needs both address and data, and no pending response
    assign wr_accept   = bus.awvalid && bus.wvalid && !bvalid_q;
    assign bus.awready = wr_accept;
    assign bus.wready  = wr_accept;
    assign bus.bvalid  = bvalid_q;
    assign bus.bresp   = bresp_q;

    // read address taken whenever the read response slot is free
    assign bus.arready = !rvalid_q;
    assign rd_accept   = bus.arvalid && !rvalid_q;
    assign bus.rvalid  = rvalid_q;
    assign bus.rresp   = rresp_q;
    assign bus.rdata   = rdata_q;

    // wstrb is ignored and every write is a full word
    assign tx_data_o = bus.wdata;

    // status word from live fifo flags
    always_comb begin
        status                                   = '0;
        status[ST_TX_EMPTY]                      = tx_empty_i;
        status[ST_TX_FULL]                       = tx_full_i;
        status[ST_RX_EMPTY]                      = rx_empty_i;
        status[ST_RX_FULL]                       = rx_full_i;
        // head content is only meaningful while something is queued
        status[ST_RX_LAST]                       = rx_head_i.last && !rx_empty_i;
        status[ST_TX_USAGE_LSB +: TX_USAGE_W]    = tx_usage_i;
        status[ST_RX_USAGE_LSB +: RX_USAGE_W]    = rx_usage_i;
    end

    // write decode, side effects only in the acceptance cycle
    always_comb begin
        tx_push_o  = 1'b0;
        tx_flush_o = 1'b0;
        rx_flush_o = 1'b0;
        bresp_d    = RESP_SLVERR;
        if (wr_accept) begin
            case (bus.awaddr)
                REG_TXDATA: begin
                    // full fifo drops the word
                    if (!tx_full_i) begin
                        tx_push_o = 1'b1;
                        bresp_d   = RESP_OKAY;
                    end
                end
                REG_CTRL: begin
                    tx_flush_o = bus.wdata[CTRL_TX_FLUSH];
                    rx_flush_o = bus.wdata[CTRL_RX_FLUSH];
                    bresp_d    = RESP_OKAY;
                end
                default: begin
                    bresp_d = RESP_SLVERR;
                end
            endcase
        end
    end

    // read decode
    always_comb begin
        rx_pop_o = 1'b0;
        rresp_d  = RESP_SLVERR;
        rdata_d  = '0;
        if (rd_accept) begin
            case (bus.araddr)
                REG_RXDATA: begin
                    // empty fifo answers an error with zero data
                    if (!rx_empty_i) begin
                        rx_pop_o = 1'b1;
                        rresp_d  = RESP_OKAY;
                        rdata_d  = rx_head_i.data;
                    end
                end
                REG_STATUS: begin
                    rresp_d = RESP_OKAY;
                    rdata_d = status;
                end
                default: begin
                    rresp_d = RESP_SLVERR;
                end
            endcase
        end
    end

    // response valid flags
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_accept) begin
                bvalid_q <= 1'b1;
            end else if (bus.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_accept) begin
                rvalid_q <= 1'b1;
            end else if (bus.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // response payload held until the handshake
    always_ff @(posedge clk_i) begin
        if (wr_accept) begin
            bresp_q <= bresp_d;
        end
        if (rd_accept) begin
            rresp_q <= rresp_d;
            rdata_q <= rdata_d;
        end
    end

endmodule

// File: src/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    // head follows data_i directly while empty
    parameter bit          FALL_THROUGH = 1'b0,
    // any depth of at least two
    parameter int unsigned DEPTH        = 8,
    parameter type         payload_t    = logic [31:0]
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    // status
    output logic                     full_o,
    output logic                     empty_o,
    output logic [$clog2(DEPTH)-1:0] usage_o,
    // write side
    input  payload_t                 data_i,
    input  logic                     push_i,
    // read side
    output payload_t                 data_o,
    input  logic                     pop_i
);
    localparam int unsigned PtrW = $clog2(DEPTH);

    // storage
    payload_t mem_q [DEPTH];

    // read and write pointers
    logic [PtrW-1:0] rd_ptr_q;
    logic [PtrW-1:0] rd_ptr_d;
    logic [PtrW-1:0] wr_ptr_q;
    logic [PtrW-1:0] wr_ptr_d;

    // one extra bit so that a full fifo is distinct from an empty one
    logic [PtrW:0] cnt_q;
    logic [PtrW:0] cnt_d;

    // item passes straight from input to output
    logic bypass;
    logic mem_we;

    // advance a pointer and wrap at the last entry
    function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
        logic [PtrW-1:0] nxt;
        if (ptr == PtrW'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // flags from the registered count
    assign full_o  = (cnt_q == (PtrW+1)'(DEPTH));
    assign empty_o = (cnt_q == '0) && !(FALL_THROUGH && push_i);
    // wraps to zero when full
    assign usage_o = cnt_q[PtrW-1:0];

    // an empty fall-through fifo forwards the incoming item
    assign bypass = FALL_THROUGH && (cnt_q == '0) && push_i && pop_i;
    assign mem_we = push_i && !bypass;

    // head of queue, or the input while empty in fall-through mode
    always_comb begin
        if (FALL_THROUGH && (cnt_q == '0)) begin
            data_o = data_i;
        end else begin
            data_o = mem_q[rd_ptr_q];
        end
    end

    // next pointer and count
    always_comb begin
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        cnt_d    = cnt_q;
        if (!bypass) begin
            if (push_i) begin
                wr_ptr_d = next_ptr(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_d = next_ptr(rd_ptr_q);
            end
            // push and pop together leave the count alone
            if (push_i && !pop_i) begin
                cnt_d = cnt_q + 1'b1;
            end else if (pop_i && !push_i) begin
                cnt_d = cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            // flush wins over any push or pop in the same cycle
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

    // payload storage
    always_ff @(posedge clk_i) begin
        if (mem_we) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

// File: src/axil_if.sv
`timescale 1ns/1ps

interface axil_if;
    import mbox_pkg::*;

    // write address channel
    logic [ADDR_W-1:0]   awaddr;
    logic                awvalid;
    logic                awready;
    // write data channel
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] wstrb;
    logic                wvalid;
    logic                wready;
    // write response channel
    logic [1:0]          bresp;
    logic                bvalid;
    logic                bready;
    // read address channel
    logic [ADDR_W-1:0]   araddr;
    logic                arvalid;
    logic                arready;
    // read data channel
    logic [DATA_W-1:0]   rdata;
    logic [1:0]          rresp;
    logic                rvalid;
    logic                rready;

    modport master (
        output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

    modport slave (
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

endinterface

// File: src/mbox_pkg.sv
package mbox_pkg;

    // bus and data widths
    localparam int unsigned DATA_W = 32;
    localparam int unsigned ADDR_W = 4;

    // fifo depths
    localparam int unsigned TX_DEPTH = 8;
    localparam int unsigned RX_DEPTH = 4;

    // usage ports are count modulo depth
    localparam int unsigned TX_USAGE_W = $clog2(TX_DEPTH);
    localparam int unsigned RX_USAGE_W = $clog2(RX_DEPTH);

    // register byte offsets
    localparam logic [ADDR_W-1:0] REG_TXDATA = 4'h0;
    localparam logic [ADDR_W-1:0] REG_RXDATA = 4'h4;
    localparam logic [ADDR_W-1:0] REG_STATUS = 4'h8;
    localparam logic [ADDR_W-1:0] REG_CTRL   = 4'hC;

    // ctrl register bits
    localparam int unsigned CTRL_TX_FLUSH = 0;
    localparam int unsigned CTRL_RX_FLUSH = 1;

    // status register bit positions
    localparam int unsigned ST_TX_EMPTY     = 0;
    localparam int unsigned ST_TX_FULL      = 1;
    localparam int unsigned ST_RX_EMPTY     = 2;
    localparam int unsigned ST_RX_FULL      = 3;
    localparam int unsigned ST_RX_LAST      = 4;
    localparam int unsigned ST_TX_USAGE_LSB = 8;
    localparam int unsigned ST_RX_USAGE_LSB = 12;

    // axi response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // receive payload
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } rx_item_t;

endpackage
